// ==== filelist.f ====
+incdir+logic
logic/ex_pkg.sv
logic/ex_regfile.sv
logic/ex_decode.sv
logic/ex_forward.sv
logic/ex_alu.sv
logic/ex_execute.sv
logic/ex_memwb.sv
logic/ex_core.sv
tb/tb_ex_core.sv

// ==== logic/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::alu_op_e         i_op,
    input  wire [`EX_NB_DATA-1:0]   i_a,
    input  wire [`EX_NB_DATA-1:0]   i_b,
    input  wire [4:0]               i_shamt,
    output logic [`EX_NB_DATA-1:0]  o_result
);
    import ex_pkg::*;

    always_comb begin
        case (i_op)
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_NOR: begin
                o_result = ~(i_a | i_b);
            end
            ALU_SLT: begin
                // signed compare
                o_result = {{(`EX_NB_DATA-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
            end
            ALU_SLL: begin
                o_result = i_b << i_shamt;
            end
            ALU_SRL: begin
                o_result = i_b >> i_shamt;
            end
            ALU_LUI: begin
                o_result = {i_b[15:0], 16'b0};
            end
            default: begin
                // pass operand b
                o_result = i_b;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_consts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths
`define EX_NB_DATA      32
`define EX_NB_REG       5
`define EX_DMEM_WORDS   64

// primary opcodes
`define EX_OP_RTYPE     6'b000000
`define EX_OP_ADDI      6'b001000
`define EX_OP_SLTI      6'b001010
`define EX_OP_ANDI      6'b001100
`define EX_OP_ORI       6'b001101
`define EX_OP_XORI      6'b001110
`define EX_OP_LUI       6'b001111
`define EX_OP_LW        6'b100011
`define EX_OP_SW        6'b101011

// r-type function field
`define EX_FN_SLL       6'b000000
`define EX_FN_SRL       6'b000010
`define EX_FN_ADD       6'b100000
`define EX_FN_SUB       6'b100010
`define EX_FN_AND       6'b100100
`define EX_FN_OR        6'b100101
`define EX_FN_XOR       6'b100110
`define EX_FN_SLT       6'b101010

`endif

// ==== logic/ex_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_core (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_halt,
    input  ex_pkg::wb_m2s_t         i_wb,
    output logic                    o_wb_ack,
    input  wire [`EX_NB_REG-1:0]    i_dbg_addr,
    output logic [`EX_NB_DATA-1:0]  o_dbg_data
);
    import ex_pkg::*;

    logic [`EX_NB_REG-1:0]  rs;
    logic [`EX_NB_REG-1:0]  rt;
    logic [`EX_NB_DATA-1:0] rs_data;
    logic [`EX_NB_DATA-1:0] rt_data;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    mem_wb_t                mem_wb;
    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;

    ex_decode u_decode (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_halt     (i_halt),
        .i_wb       (i_wb),
        .o_wb_ack   (o_wb_ack),
        .o_rs       (rs),
        .o_rt       (rt),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_id_ex    (id_ex)
    );

    ex_regfile u_regfile (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rs       (rs),
        .i_rt       (rt),
        .i_dbg_addr (i_dbg_addr),
        .i_wb       (mem_wb),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_data)
    );

    ex_forward u_forward (
        .i_id_ex    (id_ex),
        .i_ex_mem   (ex_mem),
        .i_mem_wb   (mem_wb),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b)
    );

    ex_execute u_execute (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_halt      (i_halt),
        .i_id_ex     (id_ex),
        .i_fwd_a     (fwd_a),
        .i_fwd_b     (fwd_b),
        .i_ex_mem_fb (ex_mem),
        .i_mem_wb_fb (mem_wb),
        .o_ex_mem    (ex_mem)
    );

    ex_memwb #(
        .DMEM_WORDS (`EX_DMEM_WORDS)
    ) u_memwb (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_halt     (i_halt),
        .i_ex_mem   (ex_mem),
        .o_mem_wb   (mem_wb)
    );

endmodule

`default_nettype wire

// ==== logic/ex_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_decode (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_halt,
    input  ex_pkg::wb_m2s_t         i_wb,
    output logic                    o_wb_ack,
    output logic [`EX_NB_REG-1:0]   o_rs,
    output logic [`EX_NB_REG-1:0]   o_rt,
    input  wire [`EX_NB_DATA-1:0]   i_rs_data,
    input  wire [`EX_NB_DATA-1:0]   i_rt_data,
    output ex_pkg::id_ex_t          o_id_ex
);
    import ex_pkg::*;

    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [`EX_NB_REG-1:0]   rd;
    logic [4:0]              shamt;
    logic [15:0]             imm16;
    logic [`EX_NB_DATA-1:0]  imm_ext;
    logic [`EX_NB_REG-1:0]   dest;
    logic                    zero_ext;
    logic                    bus_req;
    logic                    load_use;
    ctrl_t                   ctrl;
    alu_op_e                 alu_op;

    assign opcode = i_wb.dat[31:26];
    assign o_rs   = i_wb.dat[25:21];
    assign o_rt   = i_wb.dat[20:16];
    assign rd     = i_wb.dat[15:11];
    assign shamt  = i_wb.dat[10:6];
    assign funct  = i_wb.dat[5:0];
    assign imm16  = i_wb.dat[15:0];

    always_comb begin
        ctrl     = '0;
        alu_op   = ALU_PASS;
        zero_ext = 1'b0;
        case (opcode)
            `EX_OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    `EX_FN_ADD: alu_op = ALU_ADD;
                    `EX_FN_SUB: alu_op = ALU_SUB;
                    `EX_FN_AND: alu_op = ALU_AND;
                    `EX_FN_OR:  alu_op = ALU_OR;
                    `EX_FN_XOR: alu_op = ALU_XOR;
                    `EX_FN_SLT: alu_op = ALU_SLT;
                    `EX_FN_SLL: alu_op = ALU_SLL;
                    `EX_FN_SRL: alu_op = ALU_SRL;
                    default:    ctrl.reg_write = 1'b0;
                endcase
            end
            `EX_OP_ADDI, `EX_OP_SLTI, `EX_OP_LUI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                alu_op = (opcode == `EX_OP_ADDI) ? ALU_ADD :
                         (opcode == `EX_OP_SLTI) ? ALU_SLT : ALU_LUI;
            end
            `EX_OP_ANDI, `EX_OP_ORI, `EX_OP_XORI: begin
                // logical immediates are zero-extended
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                zero_ext       = 1'b1;
                alu_op = (opcode == `EX_OP_ANDI) ? ALU_AND :
                         (opcode == `EX_OP_ORI)  ? ALU_OR : ALU_XOR;
            end
            `EX_OP_LW: begin
                ctrl.use_imm    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                alu_op          = ALU_ADD;
            end
            `EX_OP_SW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                alu_op         = ALU_ADD;
            end
            default: begin
                alu_op = ALU_PASS;
            end
        endcase
    end

    assign imm_ext = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    assign dest    = (opcode == `EX_OP_RTYPE) ? rd : o_rt;

    // load in ID/EX feeding the word on the bus
    assign bus_req  = i_wb.cyc && i_wb.stb && i_wb.we;
    assign load_use = bus_req && o_id_ex.valid && o_id_ex.ctrl.mem_read &&
                      ((o_id_ex.dest == o_rs) || (o_id_ex.dest == o_rt));
    assign o_wb_ack = bus_req && !load_use && !i_halt;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (!i_halt) begin
            // no ack means a bubble
            o_id_ex.ctrl   <= o_wb_ack ? ctrl : '0;
            o_id_ex.rs     <= o_rs;
            o_id_ex.rt     <= o_rt;
            o_id_ex.dest   <= dest;
            o_id_ex.reg_a  <= i_rs_data;
            o_id_ex.reg_b  <= i_rt_data;
            o_id_ex.imm    <= imm_ext;
            o_id_ex.shamt  <= shamt;
            o_id_ex.alu_op <= alu_op;
            o_id_ex.valid  <= o_wb_ack;
        end
    end

    a_ack_needs_stb: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_wb_ack |-> (i_wb.stb && i_wb.cyc));

endmodule

`default_nettype wire

// ==== logic/ex_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_execute (
    input  wire                 clk,
    input  wire                 i_rst_n,
    input  wire                 i_halt,
    input  ex_pkg::id_ex_t      i_id_ex,
    input  ex_pkg::fwd_sel_e    i_fwd_a,
    input  ex_pkg::fwd_sel_e    i_fwd_b,
    input  ex_pkg::ex_mem_t     i_ex_mem_fb,
    input  ex_pkg::mem_wb_t     i_mem_wb_fb,
    output ex_pkg::ex_mem_t     o_ex_mem
);
    import ex_pkg::*;

    logic [`EX_NB_DATA-1:0] opnd_a;
    logic [`EX_NB_DATA-1:0] fwd_b_val;
    logic [`EX_NB_DATA-1:0] opnd_b;
    logic [`EX_NB_DATA-1:0] alu_result;

    always_comb begin
        case (i_fwd_a)
            FWD_EXMEM: opnd_a = i_ex_mem_fb.result;
            FWD_MEMWB: opnd_a = i_mem_wb_fb.value;
            default:   opnd_a = i_id_ex.reg_a;
        endcase
    end

    always_comb begin
        case (i_fwd_b)
            FWD_EXMEM: fwd_b_val = i_ex_mem_fb.result;
            FWD_MEMWB: fwd_b_val = i_mem_wb_fb.value;
            default:   fwd_b_val = i_id_ex.reg_b;
        endcase
    end

    // store data keeps the register value, not the offset
    assign opnd_b = i_id_ex.ctrl.use_imm ? i_id_ex.imm : fwd_b_val;

    ex_alu u_alu (
        .i_op       (i_id_ex.alu_op),
        .i_a        (opnd_a),
        .i_b        (opnd_b),
        .i_shamt    (i_id_ex.shamt),
        .o_result   (alu_result)
    );

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else if (!i_halt) begin
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
            o_ex_mem.dest       <= i_id_ex.dest;
            o_ex_mem.result     <= alu_result;
            o_ex_mem.store_data <= fwd_b_val;
            o_ex_mem.valid      <= i_id_ex.valid;
        end
    end

    a_no_rd_and_wr: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_id_ex.valid |-> !(i_id_ex.ctrl.mem_read && i_id_ex.ctrl.mem_write));

endmodule

`default_nettype wire

// ==== logic/ex_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_forward (
    input  ex_pkg::id_ex_t      i_id_ex,
    input  ex_pkg::ex_mem_t     i_ex_mem,
    input  ex_pkg::mem_wb_t     i_mem_wb,
    output ex_pkg::fwd_sel_e    o_fwd_a,
    output ex_pkg::fwd_sel_e    o_fwd_b
);
    import ex_pkg::*;

    // newest producer wins
    function automatic fwd_sel_e pick_src(input logic [`EX_NB_REG-1:0] src);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (src != '0) begin
            if (i_ex_mem.valid && i_ex_mem.ctrl.reg_write && (i_ex_mem.dest == src)) begin
                sel = FWD_EXMEM;
            end else if (i_mem_wb.valid && i_mem_wb.reg_write &&
                         (i_mem_wb.dest == src)) begin
                sel = FWD_MEMWB;
            end
        end
        return sel;
    endfunction

    assign o_fwd_a = pick_src(i_id_ex.rs);
    assign o_fwd_b = pick_src(i_id_ex.rt);

endmodule

`default_nettype wire

// ==== logic/ex_memwb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_memwb #(
    parameter int DMEM_WORDS = `EX_DMEM_WORDS
) (
    input  wire                 clk,
    input  wire                 i_rst_n,
    input  wire                 i_halt,
    input  ex_pkg::ex_mem_t     i_ex_mem,
    output ex_pkg::mem_wb_t     o_mem_wb
);
    localparam int AW = $clog2(DMEM_WORDS);

    logic [`EX_NB_DATA-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0]          word_idx;
    logic [`EX_NB_DATA-1:0] load_data;
    logic                   store_en;

    // word addressed, byte offset dropped
    assign word_idx  = i_ex_mem.result[AW+1:2];
    assign load_data = dmem[word_idx];
    assign store_en  = !i_halt && i_ex_mem.valid && i_ex_mem.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[word_idx] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wb <= '0;
        end else if (!i_halt) begin
            o_mem_wb.reg_write <= i_ex_mem.valid && i_ex_mem.ctrl.reg_write;
            o_mem_wb.dest      <= i_ex_mem.dest;
            o_mem_wb.value     <= i_ex_mem.ctrl.mem_to_reg ? load_data : i_ex_mem.result;
            o_mem_wb.valid     <= i_ex_mem.valid;
        end
    end

    a_dmem_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_ex_mem.valid && (i_ex_mem.ctrl.mem_read || i_ex_mem.ctrl.mem_write)) |->
        ((i_ex_mem.result[1:0] == 2'b00) &&
         (i_ex_mem.result < 32'(DMEM_WORDS * 4))));

endmodule

`default_nettype wire

// ==== logic/ex_pkg.sv ====
`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASS
    } alu_op_e;

    // where execute takes an operand from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic reg_write;
        logic use_imm;
        logic mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`EX_NB_REG-1:0]   rs;
        logic [`EX_NB_REG-1:0]   rt;
        logic [`EX_NB_REG-1:0]   dest;
        logic [`EX_NB_DATA-1:0]  reg_a;
        logic [`EX_NB_DATA-1:0]  reg_b;
        logic [`EX_NB_DATA-1:0]  imm;
        logic [4:0]              shamt;
        alu_op_e                 alu_op;
        logic                    valid;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`EX_NB_REG-1:0]   dest;
        logic [`EX_NB_DATA-1:0]  result;
        logic [`EX_NB_DATA-1:0]  store_data;
        logic                    valid;
    } ex_mem_t;

    typedef struct packed {
        logic                    reg_write;
        logic [`EX_NB_REG-1:0]   dest;
        logic [`EX_NB_DATA-1:0]  value;
        logic                    valid;
    } mem_wb_t;

    // wishbone classic request, master to slave
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`EX_NB_DATA-1:0]  dat;
    } wb_m2s_t;

endpackage

`default_nettype wire

// ==== logic/ex_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_regfile (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire [`EX_NB_REG-1:0]    i_rs,
    input  wire [`EX_NB_REG-1:0]    i_rt,
    input  wire [`EX_NB_REG-1:0]    i_dbg_addr,
    input  ex_pkg::mem_wb_t         i_wb,
    output logic [`EX_NB_DATA-1:0]  o_rs_data,
    output logic [`EX_NB_DATA-1:0]  o_rt_data,
    output logic [`EX_NB_DATA-1:0]  o_dbg_data
);
    localparam int NUM_REGS = 2 ** `EX_NB_REG;

    logic [`EX_NB_DATA-1:0] regs [NUM_REGS];
    logic                   wr_en;

    // r0 never takes a write
    assign wr_en = i_wb.valid && i_wb.reg_write && (i_wb.dest != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.dest] <= i_wb.value;
        end
    end

    // write-through so decode sees the writeback of this cycle
    assign o_rs_data = (wr_en && (i_wb.dest == i_rs)) ? i_wb.value : regs[i_rs];
    assign o_rt_data = (wr_en && (i_wb.dest == i_rt)) ? i_wb.value : regs[i_rt];

    assign o_dbg_data = regs[i_dbg_addr];

    a_r0_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        (regs[0] == '0) && ((i_rs != '0) || (o_rs_data == '0)));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_ex_core \
    -Mdir obj_dir \
    -o tb_ex_core

./obj_dir/tb_ex_core

// ==== tb/tb_ex_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module tb_ex_core;
    import ex_pkg::*;

    localparam int NUM_REGS = 32;
    localparam int MAX_TESTS = 32;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   halt;
    wb_m2s_t                wb;
    logic                   wb_ack;
    logic [4:0]             dbg_addr;
    logic [31:0]            dbg_data;

    // stimulus table with expected stall cycles
    logic [31:0]            tbl_instr [MAX_TESTS];
    string                  tbl_name [MAX_TESTS];
    int                     tbl_halt [MAX_TESTS];
    int                     tbl_wait [MAX_TESTS];
    logic [4:0]             tbl_dest [MAX_TESTS];
    int                     n_tests;

    // reference model state
    logic [31:0]            model_regs [NUM_REGS];
    logic [31:0]            model_mem [64];
    logic [31:0]            prev_instr;
    logic [31:0]            rng_state = 32'h0ed5c9d7;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 1000;

    ex_core i_ex_core (
        .clk        (clk),
        .i_rst_n    (rst_n),
        .i_halt     (halt),
        .i_wb       (wb),
        .o_wb_ack   (wb_ack),
        .i_dbg_addr (dbg_addr),
        .o_dbg_data (dbg_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped acknowledging", cycle_cnt);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] r;
        r = next_rand();
        return r[23:8];
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {`EX_OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // executes one word by the ISA rules
    task automatic model_step(input logic [31:0] instr, output logic [4:0] dest);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] addr;
        logic [31:0] val;
        logic        wr;
        a    = model_regs[instr[25:21]];
        b    = model_regs[instr[20:16]];
        sx   = {{16{instr[15]}}, instr[15:0]};
        zx   = {16'b0, instr[15:0]};
        addr = a + sx;
        dest = instr[20:16];
        val  = '0;
        wr   = 1'b1;
        case (instr[31:26])
            `EX_OP_RTYPE: begin
                dest = instr[15:11];
                case (instr[5:0])
                    `EX_FN_ADD: val = a + b;
                    `EX_FN_SUB: val = a - b;
                    `EX_FN_AND: val = a & b;
                    `EX_FN_OR:  val = a | b;
                    `EX_FN_XOR: val = a ^ b;
                    `EX_FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `EX_FN_SLL: val = b << instr[10:6];
                    `EX_FN_SRL: val = b >> instr[10:6];
                    default:    wr = 1'b0;
                endcase
            end
            `EX_OP_ADDI: val = a + sx;
            `EX_OP_SLTI: val = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            `EX_OP_ANDI: val = a & zx;
            `EX_OP_ORI:  val = a | zx;
            `EX_OP_XORI: val = a ^ zx;
            `EX_OP_LUI:  val = {instr[15:0], 16'b0};
            `EX_OP_LW:   val = model_mem[addr[7:2]];
            `EX_OP_SW: begin
                model_mem[addr[7:2]] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && (dest != 5'd0)) begin
            model_regs[dest] = val;
        end
    endtask

    task automatic add_test(input string name, input logic [31:0] instr);
        logic [31:0] h;
        logic [4:0]  dest;
        h = next_rand();
        tbl_instr[n_tests] = instr;
        tbl_name[n_tests]  = name;
        tbl_halt[n_tests]  = int'(h[17:16]);
        // a load right before a word that names its target costs one cycle
        tbl_wait[n_tests]  = ((prev_instr[31:26] == `EX_OP_LW) &&
                              ((prev_instr[20:16] == instr[25:21]) ||
                               (prev_instr[20:16] == instr[20:16]))) ? 1 : 0;
        model_step(instr, dest);
        tbl_dest[n_tests] = dest;
        prev_instr = instr;
        n_tests++;
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        n_tests = 0;
        prev_instr = '0;
        add_test("addi_rand", enc_i(`EX_OP_ADDI, 5'd0, 5'd1, rand_imm()));
        add_test("addi_neg", enc_i(`EX_OP_ADDI, 5'd0, 5'd2, 16'hfff0));
        add_test("andi_rand", enc_i(`EX_OP_ANDI, 5'd1, 5'd3, rand_imm()));
        add_test("ori_rand", enc_i(`EX_OP_ORI, 5'd1, 5'd4, rand_imm()));
        add_test("xori_rand", enc_i(`EX_OP_XORI, 5'd2, 5'd5, rand_imm()));
        add_test("slti_neg", enc_i(`EX_OP_SLTI, 5'd2, 5'd6, 16'hfffe));
        add_test("slti_rand", enc_i(`EX_OP_SLTI, 5'd1, 5'd7, rand_imm()));
        add_test("lui_rand", enc_i(`EX_OP_LUI, 5'd0, 5'd8, rand_imm()));
        add_test("addi_r0", enc_i(`EX_OP_ADDI, 5'd1, 5'd0, 16'h0005));
        add_test("ori_r0", enc_i(`EX_OP_ORI, 5'd0, 5'd0, 16'hffff));
        // producer to consumer at distance 1 and 2
        add_test("add_chain", enc_r(`EX_FN_ADD, 5'd1, 5'd2, 5'd9, 5'd0));
        add_test("sub_dist1", enc_r(`EX_FN_SUB, 5'd9, 5'd1, 5'd10, 5'd0));
        add_test("xor_dist2", enc_r(`EX_FN_XOR, 5'd9, 5'd10, 5'd11, 5'd0));
        add_test("and_chain", enc_r(`EX_FN_AND, 5'd11, 5'd8, 5'd12, 5'd0));
        add_test("or_chain", enc_r(`EX_FN_OR, 5'd12, 5'd11, 5'd13, 5'd0));
        add_test("slt_chain", enc_r(`EX_FN_SLT, 5'd2, 5'd13, 5'd14, 5'd0));
        add_test("sll_chain", enc_r(`EX_FN_SLL, 5'd0, 5'd11, 5'd15, 5'd3));
        add_test("srl_chain", enc_r(`EX_FN_SRL, 5'd0, 5'd15, 5'd16, 5'd5));
        add_test("add_shifts", enc_r(`EX_FN_ADD, 5'd16, 5'd15, 5'd17, 5'd0));
        // memory round trips and load-use
        add_test("ori_base", enc_i(`EX_OP_ORI, 5'd0, 5'd20, 16'h0040));
        add_test("sw_base", enc_i(`EX_OP_SW, 5'd20, 5'd13, 16'h0008));
        add_test("lw_base", enc_i(`EX_OP_LW, 5'd20, 5'd21, 16'h0008));
        add_test("add_load_use", enc_r(`EX_FN_ADD, 5'd21, 5'd1, 5'd22, 5'd0));
        add_test("sw_zero", enc_i(`EX_OP_SW, 5'd0, 5'd17, 16'h0000));
        add_test("lw_zero", enc_i(`EX_OP_LW, 5'd0, 5'd23, 16'h0000));
        add_test("addi_no_dep", enc_i(`EX_OP_ADDI, 5'd0, 5'd24, 16'h0001));
        add_test("add_load_dist2", enc_r(`EX_FN_ADD, 5'd23, 5'd24, 5'd25, 5'd0));
        add_test("lw_again", enc_i(`EX_OP_LW, 5'd20, 5'd26, 16'h0008));
        add_test("sub_load_use_rt", enc_r(`EX_FN_SUB, 5'd22, 5'd26, 5'd27, 5'd0));
    endtask

    task automatic sweep_regs(input string tag, input logic expect_zero);
        logic [31:0] exp;
        for (int r = 0; r < NUM_REGS; r++) begin
            dbg_addr = 5'(r);
            @(negedge clk);
            exp = expect_zero ? 32'h0 : model_regs[r];
            check_equal($sformatf("%s r%0d", tag, r), exp, dbg_data);
            check_equal($sformatf("%s idle ack", tag), 32'h0, {31'b0, wb_ack});
            @(posedge clk);
            #2;
        end
    endtask

    task automatic issue_entry(input int idx);
        int          waits;
        logic [31:0] snap;
        waits = 0;
        snap  = '0;
        wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: tbl_instr[idx]};
        if (tbl_halt[idx] > 0) begin
            halt = 1'b1;
            // the word two back sits in EX/MEM unless a stall came between
            dbg_addr = (idx > 1) ? tbl_dest[idx-2] : 5'd1;
            for (int k = 0; k < tbl_halt[idx]; k++) begin
                @(negedge clk);
                check_equal($sformatf("%s halt ack", tbl_name[idx]), 32'h0, {31'b0, wb_ack});
                // MEM/WB may still write on the first halted edge
                if (k < 2) begin
                    snap = dbg_data;
                end else begin
                    check_equal($sformatf("%s halt dbg", tbl_name[idx]), snap, dbg_data);
                end
                @(posedge clk);
                #2;
            end
            halt = 1'b0;
        end
        @(negedge clk);
        while (!wb_ack) begin
            waits++;
            @(negedge clk);
        end
        check_equal($sformatf("%s ack wait", tbl_name[idx]), 32'(tbl_wait[idx]), 32'(waits));
        @(posedge clk);
        #2;
    endtask

    initial begin
        rst_n    = 1'b0;
        halt     = 1'b0;
        wb       = '0;
        dbg_addr = '0;
        build_table();
        cycle_limit = 8 + 6 * n_tests + 20 + 2 * NUM_REGS;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // request without cyc must not be taken
        wb = '{cyc: 1'b0, stb: 1'b1, we: 1'b1, dat: 32'h0};
        sweep_regs("reset", 1'b1);
        for (int i = 0; i < n_tests; i++) begin
            issue_entry(i);
        end
        wb = '0;
        repeat (6) @(posedge clk);
        #2;
        sweep_regs("final", 1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
